// ==== design/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // fixed upper nibble of the 24Cxx control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // 2 KiB array, 3 page bits + 8 word address bits
    localparam int ADDR_WIDTH = 11;

    // commands from the sequencer to the bit engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0,   // start or repeated start
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,   // byte out, slave acks
        CMD_READ  = 2'd3    // byte in, master acks
    } byte_cmd_t;

    // transaction sequencer states
    typedef enum logic [3:0] {
        S_IDLE    = 4'd0,
        S_START   = 4'd1,
        S_CTRL_W  = 4'd2,   // control byte, write direction
        S_ADDR    = 4'd3,   // word address byte
        S_DATA_W  = 4'd4,
        S_RESTART = 4'd5,   // read only
        S_CTRL_R  = 4'd6,
        S_DATA_R  = 4'd7,
        S_STOP    = 4'd8,
        S_DONE    = 4'd9    // ack cycle
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/i2c_byte_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface i2c_byte_if;

    eeprom_pkg::byte_cmd_t cmd;
    logic [7:0] tx_byte;
    logic last;     // read: master sends no-acknowledge
    logic req;
    logic done;
    logic [7:0] rx_byte;
    logic nack;     // sampled ack bit of a write frame

    modport seq (
        output cmd, tx_byte, last, req,
        input  done, rx_byte, nack
    );

    modport engine (
        input  cmd, tx_byte, last, req,
        output done, rx_byte, nack
    );

endinterface

`default_nettype wire

// ==== design/i2c_bit_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_engine #(
    parameter int SCL_HALF_PERIOD = 2
) (
    input  wire  CLK,
    input  wire  RESET,
    input  wire  sda_in,
    output logic scl,
    output logic sda_out,
    output logic sda_oe,
    i2c_byte_if.engine bus
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_START,
        F_STOP,
        F_BYTE
    } frame_t;

    localparam int CNT_W = $clog2(SCL_HALF_PERIOD);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_HALF_PERIOD - 1);
    localparam logic [CNT_W-1:0] CNT_MID = CNT_W'((SCL_HALF_PERIOD - 1) / 2);
    localparam logic [4:0] BYTE_LAST_HALF = 5'd17;  // 9 bits of 2 halves

    frame_t frame;
    logic [CNT_W-1:0] cnt;
    logic [4:0] half;
    logic [3:0] bit_idx;
    logic tick;
    logic last_half;
    logic drive_pt;
    logic sample_pt;
    logic accept;
    logic done_q;
    logic nack_q;
    logic rd_mode;
    logic nack_last;
    logic [7:0] tx_shift;
    logic [7:0] rx_shift;

    assign accept = (frame == F_IDLE) && bus.req;
    assign tick = (frame != F_IDLE) && (cnt == CNT_LAST);
    assign last_half = (frame == F_BYTE) ? (half == BYTE_LAST_HALF) : (half == 5'd1);
    assign bit_idx = half[4:1];

    // SDA moves one CLK after SCL falls, input sampled mid SCL high
    assign drive_pt = (frame != F_IDLE) && !half[0] && (cnt == '0);
    assign sample_pt = (frame != F_IDLE) && half[0] && (cnt == CNT_MID);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            frame <= F_IDLE;
            cnt <= '0;
            half <= '0;
            scl <= 1'b1;
            sda_out <= 1'b1;
            sda_oe <= 1'b0;
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (accept)
            begin
                cnt <= '0;
                half <= '0;
                nack_q <= 1'b0;
                case (bus.cmd)
                    eeprom_pkg::CMD_START: frame <= F_START;
                    eeprom_pkg::CMD_STOP:  frame <= F_STOP;
                    default:               frame <= F_BYTE;
                endcase
            end
            else if (frame != F_IDLE)
            begin
                cnt <= tick ? '0 : cnt + 1'b1;
                if (tick)
                begin
                    half <= half + 5'd1;
                    if (last_half)
                    begin
                        frame <= F_IDLE;
                        done_q <= 1'b1;
                        scl <= (frame == F_STOP);   // stop leaves the bus released
                    end
                    else
                        scl <= !half[0];
                end
            end

            if (drive_pt)
            begin
                case (frame)
                    F_START:
                    begin
                        sda_out <= 1'b1;    // high before SCL rises, for repeated start
                        sda_oe <= 1'b1;
                    end
                    F_STOP:
                    begin
                        sda_out <= 1'b0;
                        sda_oe <= 1'b1;
                    end
                    default:
                    begin
                        if (bit_idx == 4'd8)
                        begin
                            sda_out <= 1'b0;
                            sda_oe <= rd_mode && !nack_last; // master ack on reads
                        end
                        else
                        begin
                            sda_out <= tx_shift[7];
                            sda_oe <= !rd_mode;
                        end
                    end
                endcase
            end

            if (sample_pt)
            begin
                case (frame)
                    F_START: sda_out <= 1'b0;   // SDA falls with SCL high
                    F_STOP:
                    begin
                        sda_out <= 1'b1;
                        sda_oe <= 1'b0;
                    end
                    default:
                    begin
                        if (bit_idx == 4'd8 && !rd_mode)
                            nack_q <= sda_in;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            tx_shift <= bus.tx_byte;
            rd_mode <= (bus.cmd == eeprom_pkg::CMD_READ);
            nack_last <= bus.last;
        end
        else if (frame == F_BYTE && drive_pt && bit_idx != 4'd8)
            tx_shift <= {tx_shift[6:0], 1'b0};  // msb first

        if (frame == F_BYTE && sample_pt && bit_idx != 4'd8)
            rx_shift <= {rx_shift[6:0], sda_in};
    end

    assign bus.done = done_q;
    assign bus.nack = nack_q;
    assign bus.rx_byte = rx_shift;

    // data only moves while SCL is low, start and stop aside
    a_sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(frame inside {F_START, F_STOP}))
            |-> ($stable(sda_out) && $stable(sda_oe)));

endmodule

`default_nettype wire

// ==== design/eeprom_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module eeprom_sequencer (
    input  wire  CLK,
    input  wire  RESET,
    input  wire  wr,
    input  wire  rd,
    input  wire  [eeprom_pkg::ADDR_WIDTH-1:0] addr,
    input  wire  [7:0] wr_data,
    output logic [7:0] rd_data,
    output logic ack,
    output logic nack,
    i2c_byte_if.seq bus
);

    eeprom_pkg::seq_state_t state;
    logic pending;      // command issued but done not yet seen
    logic abort;        // a device nack was seen in this transfer
    logic is_read;
    logic [eeprom_pkg::ADDR_WIDTH-1:0] addr_q;
    logic [7:0] data_q;
    logic [7:0] ctrl_byte;

    assign ctrl_byte = {eeprom_pkg::DEVICE_CODE, addr_q[eeprom_pkg::ADDR_WIDTH-1:8], 1'b0};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= eeprom_pkg::S_IDLE;
            pending <= 1'b0;
            abort <= 1'b0;
            ack <= 1'b0;
            nack <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            if (bus.req)
                pending <= 1'b1;
            else if (bus.done)
                pending <= 1'b0;

            if (state == eeprom_pkg::S_IDLE)
            begin
                if (wr || rd)
                begin
                    state <= eeprom_pkg::S_START;
                    abort <= 1'b0;
                end
            end
            else if (state == eeprom_pkg::S_DONE)
                state <= eeprom_pkg::S_IDLE;
            else if (bus.done)
            begin
                if (bus.nack)
                    abort <= 1'b1;
                case (state)
                    eeprom_pkg::S_START:   state <= eeprom_pkg::S_CTRL_W;
                    eeprom_pkg::S_CTRL_W:
                        state <= bus.nack ? eeprom_pkg::S_STOP : eeprom_pkg::S_ADDR;
                    eeprom_pkg::S_ADDR:
                    begin
                        if (bus.nack)
                            state <= eeprom_pkg::S_STOP;
                        else if (is_read)
                            state <= eeprom_pkg::S_RESTART;
                        else
                            state <= eeprom_pkg::S_DATA_W;
                    end
                    eeprom_pkg::S_DATA_W:  state <= eeprom_pkg::S_STOP;
                    eeprom_pkg::S_RESTART: state <= eeprom_pkg::S_CTRL_R;
                    eeprom_pkg::S_CTRL_R:
                        state <= bus.nack ? eeprom_pkg::S_STOP : eeprom_pkg::S_DATA_R;
                    eeprom_pkg::S_DATA_R:  state <= eeprom_pkg::S_STOP;
                    default:
                    begin
                        state <= eeprom_pkg::S_DONE;    // stop frame finished
                        ack <= 1'b1;
                        nack <= abort;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::S_IDLE && (wr || rd))
        begin
            is_read <= !wr;     // wr wins
            addr_q <= addr;
            data_q <= wr_data;
        end
        if (state == eeprom_pkg::S_DATA_R && bus.done)
            rd_data <= bus.rx_byte;
    end

    assign bus.req = !pending
        && !(state inside {eeprom_pkg::S_IDLE, eeprom_pkg::S_DONE});

    always_comb
    begin
        bus.cmd = eeprom_pkg::CMD_WRITE;
        bus.tx_byte = 8'h00;
        bus.last = 1'b0;
        case (state)
            eeprom_pkg::S_START,
            eeprom_pkg::S_RESTART: bus.cmd = eeprom_pkg::CMD_START;
            eeprom_pkg::S_STOP:    bus.cmd = eeprom_pkg::CMD_STOP;
            eeprom_pkg::S_CTRL_W:  bus.tx_byte = ctrl_byte;
            eeprom_pkg::S_CTRL_R:  bus.tx_byte = ctrl_byte | 8'h01;  // read direction
            eeprom_pkg::S_ADDR:    bus.tx_byte = addr_q[7:0];
            eeprom_pkg::S_DATA_W:  bus.tx_byte = data_q;
            eeprom_pkg::S_DATA_R:
            begin
                bus.cmd = eeprom_pkg::CMD_READ;
                bus.last = 1'b1;    // single byte so master no-acknowledge
            end
            default: ;
        endcase
    end

    // a new command only follows a finished frame or a fresh request
    a_req_not_outstanding: assert property (@(posedge CLK) disable iff (RESET)
        bus.req |-> ($past(bus.done) || $past(state) == eeprom_pkg::S_IDLE));

    a_ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    a_state_legal: assert property (@(posedge CLK) disable iff (RESET)
        state inside {eeprom_pkg::S_IDLE, eeprom_pkg::S_START, eeprom_pkg::S_CTRL_W,
                      eeprom_pkg::S_ADDR, eeprom_pkg::S_DATA_W, eeprom_pkg::S_RESTART,
                      eeprom_pkg::S_CTRL_R, eeprom_pkg::S_DATA_R, eeprom_pkg::S_STOP,
                      eeprom_pkg::S_DONE});

endmodule

`default_nettype wire

// ==== design/eeprom_master_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module eeprom_master_top #(
    parameter int SCL_HALF_PERIOD = 2   // CLK cycles per SCL half period
) (
    input  wire  CLK,
    input  wire  RESET,
    input  wire  wr,
    input  wire  rd,
    input  wire  [10:0] addr,
    input  wire  [7:0] wr_data,
    input  wire  sda_in,
    output logic [7:0] rd_data,
    output logic ack,
    output logic nack,
    output logic scl,
    output logic sda_out,
    output logic sda_oe
);

    i2c_byte_if i_byte_bus ();

    eeprom_sequencer i_seq (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .nack    (nack),
        .bus     (i_byte_bus.seq)
    );

    // open-drain pad split into out/oe/in
    i2c_bit_engine #(
        .SCL_HALF_PERIOD (SCL_HALF_PERIOD)
    ) i_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .bus     (i_byte_bus.engine)
    );

endmodule

`default_nettype wire

// ==== verification/eeprom_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module eeprom_model (
    input  wire  scl,
    input  wire  sda,
    input  wire  busy,      // withholds acknowledge of the control byte
    output logic pull_low,
    output int   bus_errors,
    output int   ctrl_errors
);

    typedef enum {P_IDLE, P_CTRL, P_ADDR, P_DATA, P_READ, P_IGNORE} phase_t;

    logic [7:0] mem [0:2047];
    phase_t phase;
    int bits_seen;          // SCL rising edges since start or last ack slot
    logic [7:0] shift;
    logic [7:0] rd_byte;
    logic [2:0] page;
    logic [7:0] word;
    logic addr_set;
    logic slave_tx;
    logic start_tx;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i * 37 + (i >> 8));
        phase = P_IDLE;
        bits_seen = 0;
        pull_low = 1'b0;
        bus_errors = 0;
        ctrl_errors = 0;
        addr_set = 1'b0;
        slave_tx = 1'b0;
        start_tx = 1'b0;
        page = '0;
        word = '0;
    end

    task automatic take_byte();
        case (phase)
            P_CTRL:
            begin
                if (shift[7:4] != eeprom_pkg::DEVICE_CODE || shift[0] != addr_set)
                    ctrl_errors++;
                if (busy)
                    phase = P_IGNORE;
                else
                begin
                    pull_low = 1'b1;
                    page = shift[3:1];
                    if (shift[0])
                    begin
                        phase = P_READ;
                        start_tx = 1'b1;
                        rd_byte = mem[{page, word}];
                    end
                    else
                        phase = P_ADDR;
                end
            end
            P_ADDR:
            begin
                word = shift;
                addr_set = 1'b1;
                pull_low = 1'b1;
                phase = P_DATA;
            end
            P_DATA:
            begin
                mem[{page, word}] = shift;
                pull_low = 1'b1;
                phase = P_IGNORE;
            end
            default: ;
        endcase
    endtask

    // start, also repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            if (phase != P_IDLE && bits_seen > 1)
                bus_errors++;   // SDA moved in the middle of a byte
            phase = P_CTRL;
            bits_seen = 0;
            slave_tx = 1'b0;
            start_tx = 1'b0;
            pull_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1 && phase != P_IDLE)
        begin
            if (bits_seen > 1)
                bus_errors++;
            phase = P_IDLE;     // stop
            addr_set = 1'b0;
            slave_tx = 1'b0;
            pull_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (phase != P_IDLE)
        begin
            bits_seen++;
            if (slave_tx && bits_seen == 9)
            begin
                slave_tx = 1'b0;    // single byte reads only
                phase = P_IGNORE;
            end
            else if (bits_seen <= 8)
                shift = {shift[6:0], sda};
        end
    end

    always @(negedge scl)
    begin
        if (phase != P_IDLE)
        begin
            if (bits_seen == 9)
            begin
                bits_seen = 0;
                pull_low = start_tx ? !rd_byte[7] : 1'b0;
                slave_tx = start_tx;
                start_tx = 1'b0;
            end
            else if (slave_tx)
                pull_low = (bits_seen < 8) ? !rd_byte[7 - bits_seen] : 1'b0;
            else if (bits_seen == 8)
                take_byte();
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_eeprom_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_eeprom_master;

    localparam int HALF = 2;

    logic CLK = 1'b0;
    logic RESET;
    logic wr;
    logic rd;
    logic [10:0] addr;
    logic [7:0] wr_data;
    logic busy;
    wire  [7:0] rd_data;
    wire  ack;
    wire  nack;
    wire  scl;
    wire  sda_out;
    wire  sda_oe;
    wire  pull_low;
    wire  sda;
    int bus_errors;
    int ctrl_errors;

    logic [7:0] mirror [0:2047];
    string op_q[$];
    string addr_q[$];
    logic [7:0] data_q[$];
    logic busy_q[$];
    logic exp_nack_q[$];
    int errors = 0;
    int cycles = 0;
    int limit = 100000;
    int acks = 0;
    int strobes = 0;
    int seed = 99967;
    int prev_bus = 0;
    int prev_ctrl = 0;
    logic [10:0] cur_addr;
    logic [10:0] last_addr = '0;
    logic [7:0] last_rd;

    // open-drain SDA, wired-AND of both drivers
    assign sda = (sda_oe ? sda_out : 1'b1) & !pull_low;

    eeprom_master_top #(
        .SCL_HALF_PERIOD (HALF)
    ) i_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda),
        .rd_data (rd_data),
        .ack     (ack),
        .nack    (nack),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

    eeprom_model i_model (
        .scl         (scl),
        .sda         (sda),
        .busy        (busy),
        .pull_low    (pull_low),
        .bus_errors  (bus_errors),
        .ctrl_errors (ctrl_errors)
    );

    always #2 CLK = !CLK;

    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (ack === 1'b1)
            acks = acks + 1;
        if (cycles > limit)
        begin
            $display("timeout after %0d cycles, no ack from the DUT", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic read_file();
        int fd;
        int d;
        int b;
        int n;
        string line;
        string op;
        string a;
        fd = $fopen("verification/eeprom_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file");
            errors++;
            return;
        end
        while ($fgets(line, fd))
        begin
            if (line.len() < 2 || line[0] == 8'h23)
                continue;   // comment or blank
            if ($sscanf(line, "%s %s %h %d %d", op, a, d, b, n) == 5)
            begin
                op_q.push_back(op);
                addr_q.push_back(a);
                data_q.push_back(8'(d));
                busy_q.push_back(b != 0);
                exp_nack_q.push_back(n != 0);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle_bus();
        if (ack !== 1'b0 || nack !== 1'b0 || sda_oe !== 1'b0 || scl !== 1'b1)
        begin
            $display("bus not idle around reset: ack %b nack %b sda_oe %b scl %b",
                     ack, nack, sda_oe, scl);
            errors++;
        end
    endtask

    // drives the strobe in the current cycle and waits for ack
    task automatic run_line(int i);
        logic [7:0] exp_data;
        if (addr_q[i] == "rand")
            cur_addr = 11'($random(seed));
        else if (addr_q[i] == "last")
            cur_addr = last_addr;
        else
            void'($sscanf(addr_q[i], "%h", cur_addr));
        last_addr = cur_addr;
        busy <= busy_q[i];
        addr <= cur_addr;
        wr_data <= data_q[i];
        if (op_q[i] == "W")
            wr <= 1'b1;
        else
            rd <= 1'b1;
        strobes++;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        do
            @(posedge CLK);
        while (ack !== 1'b1);

        if (nack !== exp_nack_q[i])
        begin
            $display("mismatch line %0d nack: got %h expected %h", i, nack, exp_nack_q[i]);
            errors++;
        end
        if (op_q[i] == "W")
        begin
            if (!busy_q[i])
                mirror[cur_addr] = data_q[i];
        end
        else
        begin
            exp_data = busy_q[i] ? last_rd : mirror[cur_addr];
            if (rd_data !== exp_data)
            begin
                $display("mismatch line %0d rd_data: got %h expected %h",
                         i, rd_data, exp_data);
                errors++;
            end
            last_rd = exp_data;
        end
        if (bus_errors != prev_bus)
        begin
            $display("line %0d: SDA changed while SCL was high inside a byte", i);
            errors++;
            prev_bus = bus_errors;
        end
        if (ctrl_errors != prev_ctrl)
        begin
            $display("line %0d: device saw a wrong control byte", i);
            errors++;
            prev_ctrl = ctrl_errors;
        end
    endtask

    initial
    begin
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wr_data = '0;
        busy = 1'b0;
        for (int a = 0; a < 2048; a++)
            mirror[a] = 8'(a * 37 + (a >> 8));  // same fill as the device
        read_file();
        // ten byte frames per transaction is plenty
        limit = 10 + op_q.size() * 10 * 9 * 2 * HALF + 100;
        if (op_q.size() == 0)
        begin
            $display("no transactions found in the test data file");
            errors++;
        end

        for (int c = 0; c < 10; c++)
        begin
            @(posedge CLK);
            if (c > 0)
                check_idle_bus();
        end
        RESET <= 1'b0;
        @(posedge CLK);
        check_idle_bus();

        for (int i = 0; i < op_q.size(); i++)
            run_line(i);

        repeat (20) @(posedge CLK);
        if (acks != strobes)
        begin
            $display("saw %0d ack pulses for %0d requests", acks, strobes);
            errors++;
        end
        $display("errors %0d, bus flags %0d, control byte flags %0d",
                 errors, bus_errors, ctrl_errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/eeprom_testdata.txt ====
# op addr data busy nack: op W or R, addr 11-bit hex or rand or last (address of line above)
# data is the write byte in hex, ignored by reads; nack is the expected result
W 012 5a 0 0
R 012 00 0 0
W 112 a5 0 0
W 712 3c 0 0
R 112 00 0 0
R 712 00 0 0
R 012 00 0 0
R 345 00 0 0
W 012 ff 1 1
R 012 00 1 1
R 012 00 0 0
W rand c3 0 0
R last 00 0 0
W rand 7e 0 0
R last 00 0 0
W 7ff 81 0 0
R 7ff 00 0 0
W 000 01 0 0
R 000 00 0 0

// ==== src.f ====
design/eeprom_pkg.sv
design/i2c_byte_if.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_master_top.sv
verification/eeprom_model.sv
verification/tb_eeprom_master.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_eeprom_master
FILELIST  := src.f
BUILD     := obj_dir
LOG       := sim.log
FAIL_MSG  := Finished with errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: compile
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
